// ==== verif/mipsTestdata.txt ====
# P <instruction word, hex>  one per word from address 0, text after the word is ignored
# T <test> <pc, hex> <register, decimal> <value, hex>  expected write-backs in retire order
# test 1, reset and alu
P 2401000a  addiu r1, r0, 10
P 34028005  ori   r2, r0, 0x8005
P 2403fffd  addiu r3, r0, -3
P 00222021  addu  r4, r1, r2
P 00232823  subu  r5, r1, r3
P 00833024  and   r6, r4, r3
P 00233825  or    r7, r1, r3
P 0061402a  slt   r8, r3, r1
P 0023482a  slt   r9, r1, r3
P 00015023  subu  r10, r0, r1
# test 2, forwarding at distance 1, 2, 3 and a write to r0
P 240b0005  addiu r11, r0, 5
P 016b6021  addu  r12, r11, r11
P 25600001  addiu r0, r11, 1
P 01806821  addu  r13, r12, r0
P 016c7023  subu  r14, r11, r12
# test 3, store and load through the data bus
P 240f0040  addiu r15, r0, 0x40
P adee0004  sw    r14, 4(r15)
P 8df00004  lw    r16, 4(r15)
P 02018821  addu  r17, r16, r1
P ade10000  sw    r1, 0(r15)
P 8df20000  lw    r18, 0(r15)
P 8df30004  lw    r19, 4(r15)
# test 4, taken beq and not-taken bne, each with a delay slot
P 2414000a  addiu r20, r0, 10
P 12810003  beq   r20, r1, 0x6c
P 24150001  addiu r21, r0, 1
P 24160099  addiu r22, r0, 0x99
P 24150077  addiu r21, r0, 0x77
P 16a80002  bne   r21, r8, 0x78
P 24170002  addiu r23, r0, 2
P 24180003  addiu r24, r0, 3
# test 5, jump
P 08000022  j     0x88
P 24190004  addiu r25, r0, 4
P 241a0055  addiu r26, r0, 0x55
P 24190066  addiu r25, r0, 0x66
P 0338d821  addu  r27, r25, r24
# test 6, ordering with loads and stores holding the pipeline
P 8dfc0000  lw    r28, 0(r15)
P adfc0008  sw    r28, 8(r15)
P 8dfd0008  lw    r29, 8(r15)
P 03bbf023  subu  r30, r29, r27
P 13bc0002  beq   r29, r28, 0xa8
P 241f0009  addiu r31, r0, 9
P 241f0033  addiu r31, r0, 0x33
P 03fe0821  addu  r1, r31, r30
T 1 00000000 1 0000000a
T 1 00000004 2 00008005
T 1 00000008 3 fffffffd
T 1 0000000c 4 0000800f
T 1 00000010 5 0000000d
T 1 00000014 6 0000800d
T 1 00000018 7 ffffffff
T 1 0000001c 8 00000001
T 1 00000020 9 00000000
T 1 00000024 10 fffffff6
T 2 00000028 11 00000005
T 2 0000002c 12 0000000a
T 2 00000034 13 0000000a
T 2 00000038 14 fffffffb
T 3 0000003c 15 00000040
T 3 00000044 16 fffffffb
T 3 00000048 17 00000005
T 3 00000050 18 0000000a
T 3 00000054 19 fffffffb
T 4 00000058 20 0000000a
T 4 00000060 21 00000001
T 4 00000070 23 00000002
T 4 00000074 24 00000003
T 5 0000007c 25 00000004
T 5 00000088 27 00000007
T 6 0000008c 28 0000000a
T 6 00000094 29 0000000a
T 6 00000098 30 00000003
T 6 000000a0 31 00000009
T 6 000000a8 1 0000000c

// ==== vlog.f ====
rtl/mipsPkg.sv
rtl/aluUnit.sv
rtl/regFile.sv
rtl/mainDecoder.sv
rtl/hazardUnit.sv
rtl/dataRam.sv
rtl/datapath.sv
rtl/mipsTop.sv
verif/tbMipsTop.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f vlog.f --top-module tbMipsTop --Mdir obj_dir
./obj_dir/VtbMipsTop | tee sim.log

if grep -q "All checks passed" sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1

// ==== verif/tbMipsTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbMipsTop;

	// one expected write-back
	typedef struct packed {
		int          test;
		logic [31:0] pc;
		logic [4:0]  rnum;
		logic [31:0] value;
	} traceT;

	logic        clk;
	logic        arstN;
	logic [31:0] pcF;
	logic [31:0] instrF;
	logic [31:0] debugWbPc;
	logic        debugWbRfWen;
	logic [4:0]  debugWbRfWnum;
	logic [31:0] debugWbRfWdata;

	logic [31:0] progMem [$];
	traceT       expQ [$];
	int          testErrors [16];
	int          testEntries [16];
	int          errorCount;
	int          passCount;
	int          failCount;
	int          testCount;
	int          cycles;
	int          cycleLimit;
	bit          timedOut;

	mipsTop u_dut (
		.clk(clk),
		.arstN(arstN),
		.pcF(pcF),
		.instrF(instrF),
		.debugWbPc(debugWbPc),
		.debugWbRfWen(debugWbRfWen),
		.debugWbRfWnum(debugWbRfWnum),
		.debugWbRfWdata(debugWbRfWdata)
	);

	always #10 clk = ~clk;

	////////////////////
	// stimulus file

	task automatic loadTestdata();
		int          fd;
		int          n;
		int          tNum;
		int          tReg;
		logic [31:0] word;
		logic [31:0] tPc;
		logic [31:0] tVal;
		string       line;
		traceT       entry;
		fd = $fopen("verif/mipsTestdata.txt", "r");
		if (fd == 0) begin
			$display("could not open verif/mipsTestdata.txt");
			errorCount++;
			return;
		end
		while ($fgets(line, fd) > 0) begin
			if (line[0] == "P") begin
				n = $sscanf(line.substr(1, line.len() - 1), "%h", word);
				if (n == 1) begin
					progMem.push_back(word);
				end else begin
					$display("unreadable program line in testdata: %s", line);
					errorCount++;
				end
			end else if (line[0] == "T") begin
				n = $sscanf(line.substr(1, line.len() - 1), "%d %h %d %h", tNum, tPc, tReg, tVal);
				if (n == 4) begin
					entry.test  = tNum;
					entry.pc    = tPc;
					entry.rnum  = tReg[4:0];
					entry.value = tVal;
					expQ.push_back(entry);
					if (tNum > testCount) begin
						testCount = tNum;
					end
				end else begin
					$display("unreadable trace line in testdata: %s", line);
					errorCount++;
				end
			end
		end
		$fclose(fd);
	endtask

	// words past the program read as zero, a no-op
	function automatic logic [31:0] fetchWord(input logic [31:0] addr);
		int idx;
		idx = {2'b00, addr[31:2]};
		if (idx < progMem.size()) begin
			return progMem[idx];
		end
		return 32'h0;
	endfunction

	////////////////////
	// checking

	task automatic checkValue(input int test, input string what,
			input logic [31:0] got, input logic [31:0] expected);
		if (got !== expected) begin
			$display("mismatch at %0d ns: test %0d %s is %h, expected %h",
				$time, test, what, got, expected);
			errorCount++;
			testErrors[test]++;
		end
	endtask

	task automatic reportTest(input int test);
		if (testErrors[test] == 0) begin
			$display("test %0d: passed, %0d write-backs", test, testEntries[test]);
			passCount++;
		end else begin
			$display("test %0d: FAILED with %0d mismatches", test, testErrors[test]);
			failCount++;
		end
	endtask

	task automatic checkRetire();
		traceT entry;
		if (expQ.size() == 0) begin
			$display("unexpected write-back of r%0d = %h from pc %h after the last expected one",
				debugWbRfWnum, debugWbRfWdata, debugWbPc);
			errorCount++;
			return;
		end
		entry = expQ.pop_front();
		testEntries[entry.test]++;
		checkValue(entry.test, "pc", debugWbPc, entry.pc);
		checkValue(entry.test, "register", {27'b0, debugWbRfWnum}, {27'b0, entry.rnum});
		checkValue(entry.test, "data", debugWbRfWdata, entry.value);
		// last entry of this test consumed
		if (expQ.size() == 0 || expQ[0].test != entry.test) begin
			reportTest(entry.test);
		end
	endtask

	// fetch port served mid-cycle from the current pc
	always @(negedge clk) begin
		instrF <= fetchWord(pcF);
	end

	// trace sampled mid-cycle, one entry per cycle with the enable high
	always @(negedge clk) begin
		if (arstN && debugWbRfWen) begin
			checkRetire();
		end
	end

	initial begin
		clk        = 1'b0;
		arstN      = 1'b0;
		instrF     = 32'h0;
		errorCount = 0;
		passCount  = 0;
		failCount  = 0;
		testCount  = 0;
		cycles     = 0;
		timedOut   = 1'b0;
		loadTestdata();
		cycleLimit = 4 * progMem.size() + 100;

		repeat (3) @(negedge clk);
		arstN = 1'b1;
		checkValue(1, "pc after reset", pcF, mipsPkg::resetVector);
		checkValue(1, "trace enable after reset", {31'b0, debugWbRfWen}, 32'h0);

		while (expQ.size() > 0 && cycles < cycleLimit) begin
			@(posedge clk);
			cycles++;
		end

		if (expQ.size() > 0) begin
			$display("timeout: trace did not complete within %0d cycles, %0d write-backs missing",
				cycleLimit, expQ.size());
			timedOut  = 1'b1;
			failCount = testCount - passCount;
		end else begin
			// a few more cycles to catch stray write-backs
			repeat (10) @(posedge clk);
		end

		$display("tests passed: %0d, failed: %0d, errors: %0d", passCount, failCount, errorCount);
		if (errorCount == 0 && !timedOut && testCount > 0 && passCount == testCount) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== rtl/mipsTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module mipsTop (
	input  logic                             clk,
	input  logic                             arstN,
	output logic [mipsPkg::dataWidth-1:0]    pcF,
	input  logic [mipsPkg::dataWidth-1:0]    instrF,
	output logic [mipsPkg::dataWidth-1:0]    debugWbPc,
	output logic                             debugWbRfWen,
	output logic [mipsPkg::regAddrWidth-1:0] debugWbRfWnum,
	output logic [mipsPkg::dataWidth-1:0]    debugWbRfWdata
);

	// wishbone data bus
	logic                          wbCyc;
	logic                          wbStb;
	logic                          wbWe;
	logic [mipsPkg::dataWidth-3:0] wbAdr;
	logic [mipsPkg::dataWidth-1:0] wbDatW;
	logic [mipsPkg::dataWidth-1:0] wbDatR;
	logic                          wbAck;

	datapath u_datapath (
		.clk(clk),
		.arstN(arstN),
		.pcF(pcF),
		.instrF(instrF),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatW(wbDatW),
		.wbDatR(wbDatR),
		.wbAck(wbAck),
		.debugWbPc(debugWbPc),
		.debugWbRfWen(debugWbRfWen),
		.debugWbRfWnum(debugWbRfWnum),
		.debugWbRfWdata(debugWbRfWdata)
	);

	dataRam u_dataRam (
		.clk(clk),
		.arstN(arstN),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatW(wbDatW),
		.wbDatR(wbDatR),
		.wbAck(wbAck)
	);

endmodule

`default_nettype wire

// ==== rtl/datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module datapath (
	input  logic                             clk,
	input  logic                             arstN,
	output logic [mipsPkg::dataWidth-1:0]    pcF,
	input  logic [mipsPkg::dataWidth-1:0]    instrF,
	output logic                             wbCyc,
	output logic                             wbStb,
	output logic                             wbWe,
	output logic [mipsPkg::dataWidth-3:0]    wbAdr,
	output logic [mipsPkg::dataWidth-1:0]    wbDatW,
	input  logic [mipsPkg::dataWidth-1:0]    wbDatR,
	input  logic                             wbAck,
	output logic [mipsPkg::dataWidth-1:0]    debugWbPc,
	output logic                             debugWbRfWen,
	output logic [mipsPkg::regAddrWidth-1:0] debugWbRfWnum,
	output logic [mipsPkg::dataWidth-1:0]    debugWbRfWdata
);

	// fetch
	logic [mipsPkg::dataWidth-1:0] pcNextF, pcPlus4F;
	// decode
	logic                             validD;
	logic [mipsPkg::dataWidth-1:0]    instrD, pcD, pcPlus4D, immExtD;
	logic [mipsPkg::dataWidth-1:0]    branchTargetD, jumpTargetD;
	logic [mipsPkg::dataWidth-1:0]    rd1D, rd2D, srcAD, srcBD;
	logic [mipsPkg::regAddrWidth-1:0] rsD, rtD, rdD;
	mipsPkg::opcodeE                  opD;
	mipsPkg::functE                   functD;
	mipsPkg::aluOpE                   aluOpD;
	logic regWriteD, regDstD, aluSrcD, immZeroExtD, memReadD, memWriteD;
	logic branchEqD, branchNeD, jumpD, takeJumpD, branchTakenD, usesBranchD, issueD;
	// execute
	logic                             validE, regWriteE, memReadE, memWriteE;
	logic                             regDstE, aluSrcE;
	mipsPkg::aluOpE                   aluOpE;
	logic [mipsPkg::dataWidth-1:0]    pcE, rd1E, rd2E, immE, srcAE, fwdBE, srcBE, aluOutE;
	logic [mipsPkg::regAddrWidth-1:0] rsE, rtE, rdE, writeRegE;
	// memory
	logic                             validM, regWriteM, memReadM, memWriteM, busOpen;
	logic [mipsPkg::dataWidth-1:0]    pcM, aluOutM, writeDataM, resultM;
	logic [mipsPkg::regAddrWidth-1:0] writeRegM;
	// write-back
	logic                             validW, regWriteW, rfWeW;
	logic [mipsPkg::dataWidth-1:0]    pcW, resultW;
	logic [mipsPkg::regAddrWidth-1:0] writeRegW;
	// hazard
	logic       forwardAD, forwardBD, busWait, flushE;
	logic [1:0] forwardAE, forwardBE;
	logic       stallF, stallD, stallE, stallM, stallW;

	////////////////////
	// fetch

	assign pcPlus4F = pcF + 32'd4;
	assign pcNextF  = takeJumpD ? jumpTargetD : branchTakenD ? branchTargetD : pcPlus4F;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pcF <= mipsPkg::resetVector;
		end else if (!stallF) begin
			pcF <= pcNextF;
		end
	end

	// IF/ID, no flush since the delay slot always runs
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			validD <= 1'b0;
		end else if (!stallD) begin
			validD <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!stallD) begin
			instrD <= instrF;
			pcD    <= pcF;
		end
	end

	////////////////////
	// decode

	assign opD    = mipsPkg::opcodeE'(instrD[31:26]);
	assign functD = mipsPkg::functE'(instrD[5:0]);
	assign rsD    = instrD[25:21];
	assign rtD    = instrD[20:16];
	assign rdD    = instrD[15:11];

	mainDecoder u_mainDecoder (
		.op(opD), .funct(functD), .regWrite(regWriteD), .regDst(regDstD),
		.aluSrc(aluSrcD), .immZeroExt(immZeroExtD), .memRead(memReadD),
		.memWrite(memWriteD), .branchEq(branchEqD), .branchNe(branchNeD),
		.jump(jumpD), .aluOp(aluOpD)
	);

	regFile u_regFile (
		.clk(clk), .we(rfWeW), .ra1(rsD), .ra2(rtD), .wa(writeRegW), .wd(resultW),
		.rd1(rd1D), .rd2(rd2D)
	);

	assign immExtD = immZeroExtD ? {16'h0000, instrD[15:0]} : {{16{instrD[15]}}, instrD[15:0]};
	assign pcPlus4D      = pcD + 32'd4;
	assign branchTargetD = pcPlus4D + {immExtD[29:0], 2'b00};
	assign jumpTargetD   = {pcPlus4D[31:28], instrD[25:0], 2'b00};

	// branch compare in decode
	assign srcAD        = forwardAD ? aluOutM : rd1D;
	assign srcBD        = forwardBD ? aluOutM : rd2D;
	assign usesBranchD  = validD && (branchEqD || branchNeD);
	assign branchTakenD = validD && ((branchEqD && srcAD == srcBD) || (branchNeD && srcAD != srcBD));
	assign takeJumpD    = validD && jumpD;
	assign issueD       = validD && !flushE;

	// ID/EX control
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			validE    <= 1'b0;
			regWriteE <= 1'b0;
			memReadE  <= 1'b0;
			memWriteE <= 1'b0;
		end else if (!stallE) begin
			validE    <= issueD;
			regWriteE <= issueD && regWriteD;
			memReadE  <= issueD && memReadD;
			memWriteE <= issueD && memWriteD;
		end
	end

	always_ff @(posedge clk) begin
		if (!stallE) begin
			pcE     <= pcD;
			aluOpE  <= aluOpD;
			regDstE <= regDstD;
			aluSrcE <= aluSrcD;
			rd1E    <= rd1D;
			rd2E    <= rd2D;
			immE    <= immExtD;
			rsE     <= rsD;
			rtE     <= rtD;
			rdE     <= rdD;
		end
	end

	////////////////////
	// execute

	always_comb begin
		case (forwardAE)
			2'b10:   srcAE = aluOutM;
			2'b01:   srcAE = resultW;
			default: srcAE = rd1E;
		endcase
		case (forwardBE)
			2'b10:   fwdBE = aluOutM;
			2'b01:   fwdBE = resultW;
			default: fwdBE = rd2E;
		endcase
	end

	assign srcBE     = aluSrcE ? immE : fwdBE;
	assign writeRegE = regDstE ? rdE : rtE;

	aluUnit u_aluUnit (.a(srcAE), .b(srcBE), .aluOp(aluOpE), .y(aluOutE));

	// EX/MEM
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			validM    <= 1'b0;
			regWriteM <= 1'b0;
			memReadM  <= 1'b0;
			memWriteM <= 1'b0;
		end else if (!stallM) begin
			validM    <= validE;
			regWriteM <= regWriteE;
			memReadM  <= memReadE;
			memWriteM <= memWriteE;
		end
	end

	always_ff @(posedge clk) begin
		if (!stallM) begin
			pcM        <= pcE;
			aluOutM    <= aluOutE;
			writeDataM <= fwdBE;
			writeRegM  <= writeRegE;
		end
	end

	////////////////////
	// memory, wishbone master

	// cycle is open while a load or store sits in memory
	assign busOpen = validM && (memReadM || memWriteM);
	assign busWait = busOpen && !wbAck;
	assign wbCyc   = busOpen;
	assign wbStb   = busOpen;
	assign wbWe    = memWriteM;
	assign wbAdr   = aluOutM[mipsPkg::dataWidth-1:2];
	assign wbDatW  = writeDataM;
	assign resultM = memReadM ? wbDatR : aluOutM;

	// MEM/WB
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			validW    <= 1'b0;
			regWriteW <= 1'b0;
		end else if (!stallW) begin
			validW    <= validM;
			regWriteW <= regWriteM;
		end
	end

	always_ff @(posedge clk) begin
		if (!stallW) begin
			pcW       <= pcM;
			resultW   <= resultM;
			writeRegW <= writeRegM;
		end
	end

	////////////////////
	// write-back and trace

	assign rfWeW = validW && regWriteW && writeRegW != '0 && !stallW;

	assign debugWbPc      = pcW;
	assign debugWbRfWen   = rfWeW;
	assign debugWbRfWnum  = writeRegW;
	assign debugWbRfWdata = resultW;

	hazardUnit u_hazardUnit (
		.rsD(rsD), .rtD(rtD), .usesBranchD(usesBranchD),
		.rsE(rsE), .rtE(rtE), .writeRegE(writeRegE), .regWriteE(regWriteE),
		.memReadE(memReadE), .writeRegM(writeRegM), .regWriteM(regWriteM),
		.memReadM(memReadM), .writeRegW(writeRegW), .regWriteW(regWriteW),
		.busWait(busWait), .forwardAD(forwardAD), .forwardBD(forwardBD),
		.forwardAE(forwardAE), .forwardBE(forwardBE), .stallF(stallF),
		.stallD(stallD), .stallE(stallE), .stallM(stallM), .stallW(stallW),
		.flushE(flushE)
	);

endmodule

`default_nettype wire

// ==== rtl/dataRam.sv ====
`timescale 1ns/1ps
`default_nettype none

module dataRam (
	input  logic                          clk,
	input  logic                          arstN,
	input  logic                          wbCyc,
	input  logic                          wbStb,
	input  logic                          wbWe,
	input  logic [mipsPkg::dataWidth-3:0] wbAdr,
	input  logic [mipsPkg::dataWidth-1:0] wbDatW,
	output logic [mipsPkg::dataWidth-1:0] wbDatR,
	output logic                          wbAck
);

	logic [mipsPkg::dataWidth-1:0]    mem [2**mipsPkg::ramAddrWidth];
	logic [mipsPkg::ramAddrWidth-1:0] wordIdx;
	logic                             request;

	// upper address bits ignored, so accesses wrap
	assign wordIdx = wbAdr[mipsPkg::ramAddrWidth-1:0];

	// new request only when no ack is out, gives one wait state
	assign request = wbCyc && wbStb && !wbAck;

	initial begin
		for (int i = 0; i < 2**mipsPkg::ramAddrWidth; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wbAck <= 1'b0;
		end else begin
			wbAck <= request;
		end
	end

	// read data held through the ack cycle
	always_ff @(posedge clk) begin
		if (request) begin
			if (wbWe) begin
				mem[wordIdx] <= wbDatW;
			end
			wbDatR <= mem[wordIdx];
		end
	end

endmodule

`default_nettype wire

// ==== rtl/hazardUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
	input  logic [mipsPkg::regAddrWidth-1:0] rsD,
	input  logic [mipsPkg::regAddrWidth-1:0] rtD,
	input  logic                             usesBranchD,
	input  logic [mipsPkg::regAddrWidth-1:0] rsE,
	input  logic [mipsPkg::regAddrWidth-1:0] rtE,
	input  logic [mipsPkg::regAddrWidth-1:0] writeRegE,
	input  logic                             regWriteE,
	input  logic                             memReadE,
	input  logic [mipsPkg::regAddrWidth-1:0] writeRegM,
	input  logic                             regWriteM,
	input  logic                             memReadM,
	input  logic [mipsPkg::regAddrWidth-1:0] writeRegW,
	input  logic                             regWriteW,
	input  logic                             busWait,
	output logic                             forwardAD,
	output logic                             forwardBD,
	output logic [1:0]                       forwardAE,
	output logic [1:0]                       forwardBE,
	output logic                             stallF,
	output logic                             stallD,
	output logic                             stallE,
	output logic                             stallM,
	output logic                             stallW,
	output logic                             flushE
);

	logic loadUseStall;
	logic branchStall;
	logic decodeStall;

	// 2'b10 = memory alu result, 2'b01 = write-back result, 2'b00 = register file
	function automatic logic [1:0] selectE(input logic [mipsPkg::regAddrWidth-1:0] src);
		logic [1:0] sel;
		sel = 2'b00;
		if (src != '0 && regWriteM && src == writeRegM) begin
			sel = 2'b10;
		end else if (src != '0 && regWriteW && src == writeRegW) begin
			sel = 2'b01;
		end
		return sel;
	endfunction

	assign forwardAE = selectE(rsE);
	assign forwardBE = selectE(rtE);

	// decode only takes alu results from memory, write-back goes via the regfile bypass
	assign forwardAD = rsD != '0 && regWriteM && !memReadM && rsD == writeRegM;
	assign forwardBD = rtD != '0 && regWriteM && !memReadM && rtD == writeRegM;

	assign loadUseStall = memReadE && (rtE == rsD || rtE == rtD);

	// branch operand still being computed in execute, or loaded in memory
	assign branchStall = usesBranchD &&
		((regWriteE && writeRegE != '0 && (writeRegE == rsD || writeRegE == rtD)) ||
		 (memReadM && writeRegM != '0 && (writeRegM == rsD || writeRegM == rtD)));

	assign decodeStall = loadUseStall || branchStall;

	// an open bus cycle freezes everything
	assign stallF = decodeStall || busWait;
	assign stallD = decodeStall || busWait;
	assign stallE = busWait;
	assign stallM = busWait;
	assign stallW = busWait;
	assign flushE = decodeStall && !busWait;

endmodule

`default_nettype wire

// ==== rtl/mainDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module mainDecoder (
	input  mipsPkg::opcodeE op,
	input  mipsPkg::functE  funct,
	output logic            regWrite,
	output logic            regDst,
	output logic            aluSrc,
	output logic            immZeroExt,
	output logic            memRead,
	output logic            memWrite,
	output logic            branchEq,
	output logic            branchNe,
	output logic            jump,
	output mipsPkg::aluOpE  aluOp
);

	always_comb begin
		// no-op unless the table says otherwise
		regWrite   = 1'b0;
		regDst     = 1'b0;
		aluSrc     = 1'b0;
		immZeroExt = 1'b0;
		memRead    = 1'b0;
		memWrite   = 1'b0;
		branchEq   = 1'b0;
		branchNe   = 1'b0;
		jump       = 1'b0;
		aluOp      = mipsPkg::aluAdd;

		case (op)
			mipsPkg::opSpecial: begin
				regDst = 1'b1;
				case (funct)
					mipsPkg::fnAddu: begin regWrite = 1'b1; aluOp = mipsPkg::aluAdd; end
					mipsPkg::fnSubu: begin regWrite = 1'b1; aluOp = mipsPkg::aluSub; end
					mipsPkg::fnAnd:  begin regWrite = 1'b1; aluOp = mipsPkg::aluAnd; end
					mipsPkg::fnOr:   begin regWrite = 1'b1; aluOp = mipsPkg::aluOr;  end
					mipsPkg::fnSlt:  begin regWrite = 1'b1; aluOp = mipsPkg::aluSlt; end
					default:         regWrite = 1'b0;
				endcase
			end
			mipsPkg::opAddiu: begin
				regWrite = 1'b1;
				aluSrc   = 1'b1;
			end
			mipsPkg::opOri: begin
				regWrite   = 1'b1;
				aluSrc     = 1'b1;
				immZeroExt = 1'b1;
				aluOp      = mipsPkg::aluOr;
			end
			// address = rs + signed offset
			mipsPkg::opLw: begin
				regWrite = 1'b1;
				aluSrc   = 1'b1;
				memRead  = 1'b1;
			end
			mipsPkg::opSw: begin
				aluSrc   = 1'b1;
				memWrite = 1'b1;
			end
			mipsPkg::opBeq: branchEq = 1'b1;
			mipsPkg::opBne: branchNe = 1'b1;
			mipsPkg::opJ:   jump     = 1'b1;
			default:        jump     = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input  logic                             clk,
	input  logic                             we,
	input  logic [mipsPkg::regAddrWidth-1:0] ra1,
	input  logic [mipsPkg::regAddrWidth-1:0] ra2,
	input  logic [mipsPkg::regAddrWidth-1:0] wa,
	input  logic [mipsPkg::dataWidth-1:0]    wd,
	output logic [mipsPkg::dataWidth-1:0]    rd1,
	output logic [mipsPkg::dataWidth-1:0]    rd2
);

	logic [mipsPkg::dataWidth-1:0] regs [2**mipsPkg::regAddrWidth];

	always_ff @(posedge clk) begin
		if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// r0 reads zero, same-cycle write is bypassed to the reader
	assign rd1 = (ra1 == '0) ? '0 : (we && ra1 == wa) ? wd : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : (we && ra2 == wa) ? wd : regs[ra2];

endmodule

`default_nettype wire

// ==== rtl/aluUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
	input  logic [mipsPkg::dataWidth-1:0] a,
	input  logic [mipsPkg::dataWidth-1:0] b,
	input  mipsPkg::aluOpE                aluOp,
	output logic [mipsPkg::dataWidth-1:0] y
);

	logic lessThan;

	// signed compare for slt
	assign lessThan = $signed(a) < $signed(b);

	always_comb begin
		case (aluOp)
			// add and sub wrap, no overflow trap
			mipsPkg::aluAdd:   y = a + b;
			mipsPkg::aluSub:   y = a - b;
			mipsPkg::aluAnd:   y = a & b;
			mipsPkg::aluOr:    y = a | b;
			mipsPkg::aluSlt:   y = {{(mipsPkg::dataWidth-1){1'b0}}, lessThan};
			mipsPkg::aluPassB: y = b;
			default:           y = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/mipsPkg.sv ====
`default_nettype none

package mipsPkg;

	// machine widths
	localparam int dataWidth    = 32;
	localparam int regAddrWidth = 5;

	// data RAM depth in words, 2**ramAddrWidth
	localparam int ramAddrWidth = 8;

	localparam logic [dataWidth-1:0] resetVector = 32'h0000_0000;

	// primary opcode, instr[31:26]
	typedef enum logic [5:0] {
		opSpecial = 6'h00,
		opJ       = 6'h02,
		opBeq     = 6'h04,
		opBne     = 6'h05,
		opAddiu   = 6'h09,
		opOri     = 6'h0d,
		opLw      = 6'h23,
		opSw      = 6'h2b
	} opcodeE;

	// function field for special, instr[5:0]
	typedef enum logic [5:0] {
		fnAddu = 6'h21,
		fnSubu = 6'h23,
		fnAnd  = 6'h24,
		fnOr   = 6'h25,
		fnSlt  = 6'h2a
	} functE;

	// alu operations
	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt,
		aluPassB
	} aluOpE;

endpackage

`default_nettype wire
